/* verilog/audio_pkg.sv */
/*
  Types and sizes shared by the stereo mixing path.
  Samples are 16-bit two's complement. A stereo pair packs left in the upper half.
  CREDITS_INIT must match what the downstream serializer grants after reset.
*/
package audio_pkg;

	//////////////////////////////////////////////////
	// Sample types

	typedef logic signed [15:0] sample_t;

	// One bit of headroom for core plus PCM
	typedef logic signed [16:0] wide_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// Bit 4 mutes, bits 3..0 give the right shift
	typedef logic [4:0] att_t;

	// Stereo cross-feed mode, 0 is plain stereo
	typedef logic [1:0] mix_t;

	//////////////////////////////////////////////////
	// Host command port

	localparam int IO_W = 16;
	localparam logic [7:0] CMD_VOLUME = 8'h26;

	//////////////////////////////////////////////////
	// Output FIFO and flow control

	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	localparam int CREDITS_INIT = 4;
	localparam int CREDIT_W = $clog2(CREDITS_INIT + 1);

	// Tick to FIFO write, capture plus three mixer stages
	localparam int MIX_LATENCY = 4;

endpackage

/* verilog/audio_in_if.sv */
`timescale 1ns/1ns
/*
  One captured sample pair with the signed mode in effect at the tick.
  valid is a single-cycle pulse per pair. The payload is held until the next pulse.
*/
interface audio_in_if;

	logic                valid;
	audio_pkg::sample_t  core_l;
	audio_pkg::sample_t  core_r;
	audio_pkg::sample_t  pcm_l;
	audio_pkg::sample_t  pcm_r;
	logic                signed_mode;

	// Capture side
	modport src (
		output valid,
		output core_l,
		output core_r,
		output pcm_l,
		output pcm_r,
		output signed_mode
	);

	// Channel mixers
	modport dst (
		input valid,
		input core_l,
		input core_r,
		input pcm_l,
		input pcm_r,
		input signed_mode
	);

endinterface

/* verilog/audio_cmd_rx.sv */
`timescale 1ns/1ns
/*
  Host command receiver. Only the volume command changes state. Other commands are
  consumed and ignored. The host must wait for o_io_ack to match i_io_clk before
  moving the strobe again. A new attenuation applies 4 cycles after the data strobe.
*/
module audio_cmd_rx (
	input  logic                         clk,
	input  logic                         resetd,
	input  logic                         i_io_sel,
	input  logic                         i_io_clk,
	input  logic [audio_pkg::IO_W-1:0]   i_io_din,
	output logic                         o_io_ack,
	output audio_pkg::att_t              o_att
);

	logic                       sel_d1;
	logic                       sel_d2;
	logic                       clk_d1;
	logic                       clk_d2;
	logic [audio_pkg::IO_W-1:0] din_d1;
	logic [audio_pkg::IO_W-1:0] din_d2;
	logic                       stb;
	logic                       stb_q;
	logic                       sel_q;
	logic [audio_pkg::IO_W-1:0] word_q;
	logic                       has_cmd;
	logic [7:0]                 cmd;

	//////////////////////////////////////////////////
	// Host bus, two register stages

	always_ff @(posedge clk) begin
		din_d1 <= i_io_din;
		din_d2 <= din_d1;
	end

	always_ff @(posedge clk) begin
		if (resetd) begin
			sel_d1   <= 1'b0;
			sel_d2   <= 1'b0;
			clk_d1   <= 1'b0;
			clk_d2   <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			sel_d1   <= i_io_sel;
			sel_d2   <= sel_d1;
			clk_d1   <= i_io_clk;
			clk_d2   <= clk_d1;
			// Third stage doubles as the previous strobe level
			o_io_ack <= clk_d2;
		end
	end

	// Strobe has risen but not yet been acknowledged
	assign stb = clk_d2 & ~o_io_ack;

	always_ff @(posedge clk) begin
		if (resetd) begin
			stb_q <= 1'b0;
			sel_q <= 1'b0;
		end else begin
			stb_q <= stb;
			sel_q <= sel_d2;
		end
	end

	always_ff @(posedge clk) begin
		if (stb)
			word_q <= din_d2;
	end

	//////////////////////////////////////////////////
	// Command decode

	always_ff @(posedge clk) begin
		if (resetd) begin
			has_cmd <= 1'b0;
			cmd     <= 8'h00;
			o_att   <= '0;
		end else if (!sel_q) begin
			// Deselect ends the command, next word is a new opcode
			has_cmd <= 1'b0;
		end else if (stb_q) begin
			if (!has_cmd) begin
				has_cmd <= 1'b1;
				cmd     <= word_q[7:0];
			end else if (cmd == audio_pkg::CMD_VOLUME) begin
				o_att <= word_q[4:0];
			end
		end
	end

endmodule

/* verilog/audio_sample_in.sv */
`timescale 1ns/1ns
/*
  Core audio deglitch and per-tick capture. Core levels come from another clock domain
  and must be held 4 cycles before a tick to be captured. The tick may come on any cycle.
  One-cycle glitches never reach the held level.
*/
module audio_sample_in (
	input  logic                clk,
	input  logic                resetd,
	input  audio_pkg::sample_t  i_core_l,
	input  audio_pkg::sample_t  i_core_r,
	input  audio_pkg::sample_t  i_pcm_l,
	input  audio_pkg::sample_t  i_pcm_r,
	input  logic                i_sample_tick,
	input  logic                i_audio_signed,
	audio_in_if.src             o_smp
);

	// Index 0 is left, 1 is right
	audio_pkg::sample_t core_raw [2];
	audio_pkg::sample_t core_d1  [2];
	audio_pkg::sample_t core_d2  [2];
	audio_pkg::sample_t core_d3  [2];
	audio_pkg::sample_t core_hold[2];

	assign core_raw[0] = i_core_l;
	assign core_raw[1] = i_core_r;

	//////////////////////////////////////////////////
	// Deglitch

	always_ff @(posedge clk) begin
		for (int ch = 0; ch < 2; ch++) begin
			core_d1[ch] <= core_raw[ch];
			core_d2[ch] <= core_d1[ch];
			core_d3[ch] <= core_d2[ch];
			// Take the level once two registered samples agree
			if (core_d2[ch] == core_d3[ch])
				core_hold[ch] <= core_d2[ch];
		end
	end

	//////////////////////////////////////////////////
	// Capture on tick

	always_ff @(posedge clk) begin
		if (resetd)
			o_smp.valid <= 1'b0;
		else
			o_smp.valid <= i_sample_tick;
	end

	always_ff @(posedge clk) begin
		if (i_sample_tick) begin
			o_smp.core_l      <= core_hold[0];
			o_smp.core_r      <= core_hold[1];
			o_smp.pcm_l       <= i_pcm_l;
			o_smp.pcm_r       <= i_pcm_r;
			o_smp.signed_mode <= i_audio_signed;
		end
	end

endmodule

/* verilog/audio_mix_chan.sv */
`timescale 1ns/1ns
/*
  One channel of the stereo mixer, three stages, no stalls.
  i_pre must come from the other channel's o_pre so both half sums line up.
  Unsigned core audio is taken as offset binary and halved before the sum.
*/
module audio_mix_chan (
	input  logic                clk,
	input  logic                resetd,
	audio_in_if.dst             i_smp,
	input  logic                i_right_side,
	input  audio_pkg::mix_t     i_mix,
	input  audio_pkg::att_t     i_att,
	input  audio_pkg::sample_t  i_pre,
	output audio_pkg::sample_t  o_pre,
	output logic                o_valid,
	output audio_pkg::sample_t  o_sample
);

	audio_pkg::sample_t core;
	audio_pkg::sample_t pcm;
	audio_pkg::wide_t   core_ext;
	audio_pkg::wide_t   sum_c;
	audio_pkg::wide_t   sum_q;
	audio_pkg::wide_t   pre_ext;
	audio_pkg::wide_t   mix_c;
	audio_pkg::wide_t   mix_q;
	audio_pkg::wide_t   att_c;
	logic [audio_pkg::MIX_LATENCY-2:0] vld_sr;

	assign core = i_right_side ? i_smp.core_r : i_smp.core_l;
	assign pcm  = i_right_side ? i_smp.pcm_r  : i_smp.pcm_l;

	//////////////////////////////////////////////////
	// Stage 1 forms the sum and half sum

	assign core_ext = i_smp.signed_mode ? {core[15], core} : {2'b00, core[15:1]};
	assign sum_c    = core_ext + {pcm[15], pcm};

	always_ff @(posedge clk) begin
		sum_q <= sum_c;
		o_pre <= sum_c[16:1];
	end

	//////////////////////////////////////////////////
	// Stage 2 applies the cross-feed

	assign pre_ext = {i_pre[15], i_pre};

	always_comb begin
		case (i_mix)
			2'd0:    mix_c = sum_q;
			2'd1:    mix_c = sum_q - (sum_q >>> 3) + (pre_ext >>> 2);
			2'd2:    mix_c = sum_q - (sum_q >>> 2) + (pre_ext >>> 1);
			default: mix_c = (sum_q >>> 1) + pre_ext;
		endcase
	end

	always_ff @(posedge clk) begin
		mix_q <= mix_c;
	end

	//////////////////////////////////////////////////
	// Stage 3 attenuates and clamps

	assign att_c = i_att[4] ? audio_pkg::wide_t'(0) : (mix_q >>> i_att[3:0]);

	always_ff @(posedge clk) begin
		// Top two bits differ means out of 16-bit range
		if (att_c[16] != att_c[15])
			o_sample <= {att_c[16], {15{att_c[15]}}};
		else
			o_sample <= att_c[15:0];
	end

	// Valid rides alongside the three data stages
	always_ff @(posedge clk) begin
		if (resetd)
			vld_sr <= '0;
		else
			vld_sr <= {vld_sr[audio_pkg::MIX_LATENCY-3:0], i_smp.valid};
	end

	assign o_valid = vld_sr[audio_pkg::MIX_LATENCY-2];

endmodule

/* verilog/audio_out_fifo.sv */
`timescale 1ns/1ns
/*
  Stereo pair FIFO with credit-based output. A pair goes out whenever the FIFO holds
  one and a credit is available. o_out_valid may stay high on back-to-back cycles.
  Pairs written while full are lost and o_overrun stays set until reset.
*/
module audio_out_fifo (
	input  logic                clk,
	input  logic                resetd,
	input  logic                i_valid,
	input  audio_pkg::stereo_t  i_data,
	output logic                o_out_valid,
	output audio_pkg::stereo_t  o_out_data,
	input  logic                i_credit_return,
	output logic                o_overrun
);

	audio_pkg::stereo_t mem [audio_pkg::FIFO_DEPTH];

	// Extra top bit tells full from empty
	logic [audio_pkg::FIFO_AW:0]     wr_ptr;
	logic [audio_pkg::FIFO_AW:0]     rd_ptr;
	logic [audio_pkg::CREDIT_W-1:0]  credits;
	logic                            empty;
	logic                            full;
	logic                            push;

	assign empty = (wr_ptr == rd_ptr);
	assign full  = (wr_ptr[audio_pkg::FIFO_AW] != rd_ptr[audio_pkg::FIFO_AW]) &&
	               (wr_ptr[audio_pkg::FIFO_AW-1:0] == rd_ptr[audio_pkg::FIFO_AW-1:0]);
	assign push  = i_valid && !full;

	//////////////////////////////////////////////////
	// Storage

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr[audio_pkg::FIFO_AW-1:0]] <= i_data;
	end

	assign o_out_valid = !empty && (credits != '0);
	assign o_out_data  = mem[rd_ptr[audio_pkg::FIFO_AW-1:0]];

	always_ff @(posedge clk) begin
		if (resetd) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (o_out_valid)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	//////////////////////////////////////////////////
	// Credits

	always_ff @(posedge clk) begin
		if (resetd) begin
			credits <= audio_pkg::CREDIT_W'(audio_pkg::CREDITS_INIT);
		end else begin
			// A send and a return in the same cycle cancel out
			case ({o_out_valid, i_credit_return})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (resetd)
			o_overrun <= 1'b0;
		else if (i_valid && full)
			o_overrun <= 1'b1;
	end

endmodule

/* verilog/audio_mixer_top.sv */
`timescale 1ns/1ns
/*
  Stereo audio mixing path. One sample pair per i_sample_tick, written to the output
  FIFO MIX_LATENCY cycles after the tick. The serializer grants CREDITS_INIT credits
  after reset and returns one per i_credit_return pulse.
*/
module audio_mixer_top (
	input  logic                         clk,
	input  logic                         resetd,

	// Host command port
	input  logic                         i_io_sel,
	input  logic                         i_io_clk,
	input  logic [audio_pkg::IO_W-1:0]   i_io_din,
	output logic                         o_io_ack,

	// Core and Linux audio
	input  audio_pkg::sample_t           i_core_l,
	input  audio_pkg::sample_t           i_core_r,
	input  audio_pkg::sample_t           i_pcm_l,
	input  audio_pkg::sample_t           i_pcm_r,
	input  logic                         i_sample_tick,
	input  audio_pkg::mix_t              i_audio_mix,
	input  logic                         i_audio_signed,

	// To the serializer
	output logic                         o_out_valid,
	output audio_pkg::stereo_t           o_out_data,
	input  logic                         i_credit_return,
	output logic                         o_overrun
);

	audio_pkg::att_t    att;
	audio_pkg::sample_t pre_l;
	audio_pkg::sample_t pre_r;
	audio_pkg::sample_t mix_l;
	audio_pkg::sample_t mix_r;
	logic               mix_valid;
	audio_pkg::stereo_t mix_pair;

	audio_in_if u_smp_if ();

	//////////////////////////////////////////////////
	// Input side

	audio_cmd_rx u_cmd_rx (
		.clk      (clk),
		.resetd   (resetd),
		.i_io_sel (i_io_sel),
		.i_io_clk (i_io_clk),
		.i_io_din (i_io_din),
		.o_io_ack (o_io_ack),
		.o_att    (att)
	);

	audio_sample_in u_sample_in (
		.clk            (clk),
		.resetd         (resetd),
		.i_core_l       (i_core_l),
		.i_core_r       (i_core_r),
		.i_pcm_l        (i_pcm_l),
		.i_pcm_r        (i_pcm_r),
		.i_sample_tick  (i_sample_tick),
		.i_audio_signed (i_audio_signed),
		.o_smp          (u_smp_if.src)
	);

	//////////////////////////////////////////////////
	// Channel mixers, half sums cross over

	audio_mix_chan u_mix_l (
		.clk          (clk),
		.resetd       (resetd),
		.i_smp        (u_smp_if.dst),
		.i_right_side (1'b0),
		.i_mix        (i_audio_mix),
		.i_att        (att),
		.i_pre        (pre_r),
		.o_pre        (pre_l),
		.o_valid      (mix_valid),
		.o_sample     (mix_l)
	);

	// Right valid matches the left one
	audio_mix_chan u_mix_r (
		.clk          (clk),
		.resetd       (resetd),
		.i_smp        (u_smp_if.dst),
		.i_right_side (1'b1),
		.i_mix        (i_audio_mix),
		.i_att        (att),
		.i_pre        (pre_l),
		.o_pre        (pre_r),
		.o_valid      (),
		.o_sample     (mix_r)
	);

	assign mix_pair = {mix_l, mix_r};

	//////////////////////////////////////////////////
	// Output side

	audio_out_fifo u_out_fifo (
		.clk             (clk),
		.resetd          (resetd),
		.i_valid         (mix_valid),
		.i_data          (mix_pair),
		.o_out_valid     (o_out_valid),
		.o_out_data      (o_out_data),
		.i_credit_return (i_credit_return),
		.o_overrun       (o_overrun)
	);

endmodule

/* verif/tb_clock.sv */
`timescale 1ns/1ns
/*
  Testbench clock and reset. 4 ns period, reset held high for the first 2 rising edges.
*/
module tb_clock (
	output logic clk,
	output logic resetd
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		resetd = 1'b1;
		repeat (2) @(posedge clk);
		resetd <= 1'b0;
	end

endmodule

/* verif/audio_mixer_properties.sv */
`timescale 1ns/1ns
/*
  Credit rules of the output FIFO, bound into every audio_out_fifo instance.
  Valid is only checked from the second reset cycle, once the pointers are cleared.
*/
module audio_mixer_properties (
	input logic                           clk,
	input logic                           resetd,
	input logic                           i_out_valid,
	input logic                           i_credit_return,
	input logic [audio_pkg::CREDIT_W-1:0] i_credits
);

	// Credits held as seen from the ports alone
	int port_credits;

	always_ff @(posedge clk) begin
		if (resetd)
			port_credits <= audio_pkg::CREDITS_INIT;
		else
			port_credits <= port_credits - int'(i_out_valid) + int'(i_credit_return);
	end

	// Never more credits than the serializer granted
	credit_bound: assert property (@(posedge clk) disable iff (resetd)
		i_credits <= audio_pkg::CREDITS_INIT)
		else $error("credit count above the initial grant");

	no_send_without_credit: assert property (@(posedge clk) disable iff (resetd)
		i_out_valid |-> (port_credits > 0))
		else $error("pair sent with no credit held");

	// Output stays quiet in reset
	quiet_in_reset: assert property (@(posedge clk)
		(resetd ##1 resetd) |-> !i_out_valid)
		else $error("output valid during reset");

endmodule

bind audio_out_fifo audio_mixer_properties u_props (
	.clk             (clk),
	.resetd          (resetd),
	.i_out_valid     (o_out_valid),
	.i_credit_return (i_credit_return),
	.i_credits       (credits)
);

/* verif/audio_mixer_tb.sv */
`timescale 1ns/1ns
/*
  Random stimulus with a fixed seed against a queue of expected stereo pairs.
  Mix mode and attenuation only change while no pair is in the pipeline.
  A serializer model returns credits after random delays and can withhold them.
*/
module audio_mixer_tb;

	localparam int TIMEOUT = 300 * 30 + 2000;

	logic                       clk;
	logic                       resetd;
	logic                       i_io_sel;
	logic                       i_io_clk;
	logic [audio_pkg::IO_W-1:0] i_io_din;
	logic                       o_io_ack;
	audio_pkg::sample_t         i_core_l;
	audio_pkg::sample_t         i_core_r;
	audio_pkg::sample_t         i_pcm_l;
	audio_pkg::sample_t         i_pcm_r;
	logic                       i_sample_tick;
	audio_pkg::mix_t            i_audio_mix;
	logic                       i_audio_signed;
	logic                       o_out_valid;
	audio_pkg::stereo_t         o_out_data;
	logic                       i_credit_return;
	logic                       o_overrun;

	// Model state
	audio_pkg::stereo_t exp_q[$];
	audio_pkg::att_t    att_model;
	audio_pkg::mix_t    mix_mode;
	logic               signed_mode;
	logic               credit_on;
	int                 owed;
	int                 ret_delay;
	int                 cycles;
	logic [2:0]         ack_hist;

	tb_clock u_clock (
		.clk    (clk),
		.resetd (resetd)
	);

	audio_mixer_top u_dut (.*);

	//////////////////////////////////////////////////
	// Failure reporting and compares

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check_stereo(input string name, input audio_pkg::stereo_t got,
			input audio_pkg::stereo_t exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	task automatic check_att_ack(input string name, input logic got, input logic exp);
		if (got !== exp)
			abort_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
	endtask

	//////////////////////////////////////////////////
	// Mixer reference model

	function automatic int chan_sum(input audio_pkg::sample_t core,
			input audio_pkg::sample_t pcm, input logic sgn);
		int c;
		if (sgn)
			c = int'(core);
		else
			c = int'({1'b0, core[15:1]});
		return c + int'(pcm);
	endfunction

	function automatic audio_pkg::sample_t mix_model(input int sum, input int other,
			input audio_pkg::mix_t mix, input audio_pkg::att_t att);
		int other_half;
		int r;
		other_half = other >>> 1;
		case (mix)
			2'd0:    r = sum;
			2'd1:    r = sum - (sum >>> 3) + (other_half >>> 2);
			2'd2:    r = sum - (sum >>> 2) + (other_half >>> 1);
			default: r = (sum >>> 1) + other_half;
		endcase
		if (att[4])
			r = 0;
		else
			r = r >>> att[3:0];
		if (r > 32767)
			r = 32767;
		else if (r < -32768)
			r = -32768;
		return audio_pkg::sample_t'(r);
	endfunction

	function automatic audio_pkg::sample_t rand_sample(input logic full_scale);
		if (full_scale)
			return ($urandom_range(1) == 1) ? 16'h7FFF : 16'h8000;
		return audio_pkg::sample_t'($urandom);
	endfunction

	//////////////////////////////////////////////////
	// Stimulus

	// New core level, optional one-cycle glitch, then the tick
	task automatic send_sample(input audio_pkg::sample_t cl, input audio_pkg::sample_t cr,
			input audio_pkg::sample_t pl, input audio_pkg::sample_t pr,
			input logic glitch, input logic keep);
		audio_pkg::stereo_t exp;
		int sl;
		int sr;
		@(posedge clk);
		i_core_l <= cl;
		i_core_r <= cr;
		repeat (5) @(posedge clk);
		if (glitch) begin
			i_core_l <= audio_pkg::sample_t'($urandom);
			i_core_r <= audio_pkg::sample_t'($urandom);
			@(posedge clk);
			i_core_l <= cl;
			i_core_r <= cr;
			repeat (2) @(posedge clk);
		end
		i_pcm_l        <= pl;
		i_pcm_r        <= pr;
		i_audio_signed <= signed_mode;
		i_sample_tick  <= 1'b1;
		@(posedge clk);
		i_sample_tick <= 1'b0;
		sl = chan_sum(cl, pl, signed_mode);
		sr = chan_sum(cr, pr, signed_mode);
		exp.left  = mix_model(sl, sr, mix_mode, att_model);
		exp.right = mix_model(sr, sl, mix_mode, att_model);
		if (keep)
			exp_q.push_back(exp);
	endtask

	// Lets the last pair reach the FIFO
	task automatic settle();
		repeat (audio_pkg::MIX_LATENCY + 4) @(posedge clk);
	endtask

	task automatic run_group(input int count, input audio_pkg::mix_t mix, input logic sgn,
			input logic full_scale);
		audio_pkg::sample_t cl;
		audio_pkg::sample_t cr;
		audio_pkg::sample_t pl;
		audio_pkg::sample_t pr;
		@(posedge clk);
		i_audio_mix <= mix;
		mix_mode    = mix;
		signed_mode = sgn;
		for (int k = 0; k < count; k++) begin
			cl = rand_sample(full_scale);
			cr = rand_sample(full_scale);
			pl = rand_sample(full_scale);
			pr = rand_sample(full_scale);
			send_sample(cl, cr, pl, pr, $urandom_range(2) == 0, 1'b1);
		end
		settle();
	endtask

	task automatic wait_ack(input logic level);
		int waited;
		waited = 0;
		while (o_io_ack !== level) begin
			@(posedge clk);
			waited++;
			if (waited > 20)
				abort_run("Acknowledge did not follow the host strobe");
		end
	endtask

	task automatic host_word(input logic [audio_pkg::IO_W-1:0] w);
		@(posedge clk);
		i_io_din <= w;
		@(posedge clk);
		i_io_clk <= 1'b1;
		@(posedge clk);
		wait_ack(1'b1);
		i_io_clk <= 1'b0;
		@(posedge clk);
		wait_ack(1'b0);
	endtask

	task automatic host_command(input logic [audio_pkg::IO_W-1:0] cmd_word,
			input logic [audio_pkg::IO_W-1:0] data_word);
		@(posedge clk);
		i_io_sel <= 1'b1;
		repeat (2) @(posedge clk);
		host_word(cmd_word);
		host_word(data_word);
		i_io_sel <= 1'b0;
		repeat (5) @(posedge clk);
		if (cmd_word[7:0] == audio_pkg::CMD_VOLUME)
			att_model = data_word[4:0];
	endtask

	task automatic wait_drained();
		while (exp_q.size() != 0 || owed != 0)
			@(posedge clk);
	endtask

	//////////////////////////////////////////////////
	// Serializer model and cycle limit

	always @(posedge clk) begin
		if (resetd) begin
			i_credit_return <= 1'b0;
			owed = 0;
			ret_delay = 0;
		end else begin
			if (o_out_valid) begin
				if (exp_q.size() == 0)
					abort_run("A pair left the FIFO when none was expected");
				else
					check_stereo("o_out_data", o_out_data, exp_q.pop_front());
				owed = owed + 1;
			end
			if (i_credit_return)
				owed = owed - 1;
			if (owed > audio_pkg::CREDITS_INIT)
				abort_run("More pairs were sent than credits were granted");
			if (credit_on && !i_credit_return && owed > 0 && ret_delay == 0) begin
				i_credit_return <= 1'b1;
				ret_delay = $urandom_range(4);
			end else begin
				i_credit_return <= 1'b0;
				if (ret_delay > 0)
					ret_delay = ret_delay - 1;
			end
		end
	end

	// Host acknowledge is the strobe three cycles late
	always @(posedge clk) begin
		if (resetd) begin
			ack_hist = '0;
		end else begin
			check_att_ack("o_io_ack", o_io_ack, ack_hist[2]);
			ack_hist = {ack_hist[1:0], i_io_clk};
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT)
			abort_run("Run did not finish within the cycle limit");
	end

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		logic [audio_pkg::IO_W-1:0] word;
		void'($urandom(9));
		i_io_sel        = 1'b0;
		i_io_clk        = 1'b0;
		i_io_din        = '0;
		i_core_l        = '0;
		i_core_r        = '0;
		i_pcm_l         = '0;
		i_pcm_r         = '0;
		i_sample_tick   = 1'b0;
		i_audio_mix     = '0;
		i_audio_signed  = 1'b0;
		i_credit_return = 1'b0;
		att_model       = '0;
		mix_mode        = '0;
		signed_mode     = 1'b0;
		credit_on       = 1'b1;
		owed            = 0;
		cycles          = 0;
		@(posedge clk);
		while (resetd) @(posedge clk);

		// All mix modes with signed and unsigned core audio
		for (int m = 0; m < 4; m++) begin
			run_group(20, audio_pkg::mix_t'(m), 1'b1, 1'b0);
			run_group(20, audio_pkg::mix_t'(m), 1'b0, 1'b0);
		end

		// Full scale to hit the clamp
		run_group(16, 2'd0, 1'b1, 1'b1);

		// Volume changes where the fifth one mutes
		for (int v = 0; v < 6; v++) begin
			word = 16'($urandom);
			if (v == 4)
				word[4] = 1'b1;
			if (v == 5)
				word[4] = 1'b0;
			host_command(16'h0026, word);
			run_group(8, audio_pkg::mix_t'($urandom_range(3)), 1'($urandom_range(1)), 1'b0);
		end

		// Other opcodes leave the attenuation alone
		for (int c = 0; c < 3; c++) begin
			word = 16'($urandom);
			if (word[7:0] == audio_pkg::CMD_VOLUME)
				word[0] = ~word[0];
			host_command(word, 16'($urandom));
			run_group(4, audio_pkg::mix_t'($urandom_range(3)), 1'($urandom_range(1)), 1'b0);
		end
		check_flag("o_overrun", o_overrun, 1'b0);

		// Withhold credits until the FIFO overflows
		wait_drained();
		credit_on = 1'b0;
		for (int k = 0; k < audio_pkg::FIFO_DEPTH + audio_pkg::CREDITS_INIT + 3; k++) begin
			send_sample(rand_sample(1'b0), rand_sample(1'b0), rand_sample(1'b0),
				rand_sample(1'b0), 1'b0, k < audio_pkg::FIFO_DEPTH + audio_pkg::CREDITS_INIT);
			settle();
			if (k == audio_pkg::FIFO_DEPTH + audio_pkg::CREDITS_INIT - 1)
				check_flag("o_overrun", o_overrun, 1'b0);
		end
		check_flag("o_overrun", o_overrun, 1'b1);
		credit_on = 1'b1;
		wait_drained();
		settle();
		check_flag("o_overrun", o_overrun, 1'b1);

		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* list.f */
verilog/audio_pkg.sv
verilog/audio_in_if.sv
verilog/audio_cmd_rx.sv
verilog/audio_sample_in.sv
verilog/audio_mix_chan.sv
verilog/audio_out_fifo.sv
verilog/audio_mixer_top.sv
verif/tb_clock.sv
verif/audio_mixer_properties.sv
verif/audio_mixer_tb.sv
